// File: hw/mmu_pkg.sv
package mmu_pkg;

    localparam int VA_W    = 32;
    localparam int PA_W    = 32;
    localparam int VPN2_W  = 19;
    localparam int PFN_W   = 20;
    localparam int ASID_W  = 8;
    localparam int CATTR_W = 3;

    localparam logic [CATTR_W-1:0] CATTR_UNCACHED = 3'd2;

    // bit positions inside the cp0 words
    localparam int LO_PFN_LSB  = 6;
    localparam int HI_VPN2_LSB = 13;
    localparam int INDEX_P_BIT = 31;

    typedef enum logic [4:0] {
        CP0_INDEX    = 5'd0,
        CP0_ENTRYLO0 = 5'd2,
        CP0_ENTRYLO1 = 5'd3,
        CP0_ENTRYHI  = 5'd10
    } cp0_reg_e;

    typedef enum logic [1:0] {
        TLB_NONE,
        TLB_P,
        TLB_R,
        TLB_WI
    } tlb_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_REFILL,
        EXC_INVALID,
        EXC_MODIFIED
    } xlate_exc_e;

    typedef union packed {
        logic [VA_W-1:0] raw;   // top three bits pick the segment
        struct packed {
            logic [VPN2_W-1:0] vpn2;
            logic              odd;
            logic [11:0]       offset;
        } mapped;
    } vaddr_u;

endpackage

// File: hw/tlb.sv
`timescale 1ns/100ps

module tlb #(
    parameter int TLBNUM = 16
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [mmu_pkg::VPN2_W-1:0]    s0_vpn2,
    input  logic                          s0_odd_page,
    input  logic [mmu_pkg::ASID_W-1:0]    s0_asid,
    output logic                          s0_found,
    output logic [mmu_pkg::PFN_W-1:0]     s0_pfn,
    output logic [mmu_pkg::CATTR_W-1:0]   s0_c,
    output logic                          s0_d,
    output logic                          s0_v,

    input  logic [mmu_pkg::VPN2_W-1:0]    s1_vpn2,
    input  logic                          s1_odd_page,
    input  logic [mmu_pkg::ASID_W-1:0]    s1_asid,
    output logic                          s1_found,
    output logic [mmu_pkg::PFN_W-1:0]     s1_pfn,
    output logic [mmu_pkg::CATTR_W-1:0]   s1_c,
    output logic                          s1_d,
    output logic                          s1_v,

    input  logic                          inst_tlbwi,
    input  logic                          inst_tlbp,
    input  logic [$clog2(TLBNUM)-1:0]     w_index,
    input  logic [mmu_pkg::VPN2_W-1:0]    w_vpn2,
    input  logic [mmu_pkg::ASID_W-1:0]    w_asid,
    input  logic                          w_g,
    input  logic [mmu_pkg::PFN_W-1:0]     w_pfn0,
    input  logic [mmu_pkg::CATTR_W-1:0]   w_c0,
    input  logic                          w_d0,
    input  logic                          w_v0,
    input  logic [mmu_pkg::PFN_W-1:0]     w_pfn1,
    input  logic [mmu_pkg::CATTR_W-1:0]   w_c1,
    input  logic                          w_d1,
    input  logic                          w_v1,

    output logic                          probe_found,
    output logic [$clog2(TLBNUM)-1:0]     probe_index,
    output logic [mmu_pkg::VPN2_W-1:0]    r_vpn2,
    output logic [mmu_pkg::ASID_W-1:0]    r_asid,
    output logic                          r_g,
    output logic [mmu_pkg::PFN_W-1:0]     r_pfn0,
    output logic [mmu_pkg::CATTR_W-1:0]   r_c0,
    output logic                          r_d0,
    output logic                          r_v0,
    output logic [mmu_pkg::PFN_W-1:0]     r_pfn1,
    output logic [mmu_pkg::CATTR_W-1:0]   r_c1,
    output logic                          r_d1,
    output logic                          r_v1
);

    localparam int IDX_W = $clog2(TLBNUM);

    logic [mmu_pkg::VPN2_W-1:0]  tlb_vpn2 [TLBNUM];
    logic [mmu_pkg::ASID_W-1:0]  tlb_asid [TLBNUM];
    logic                        tlb_g    [TLBNUM];
    logic [mmu_pkg::PFN_W-1:0]   tlb_pfn0 [TLBNUM];
    logic [mmu_pkg::CATTR_W-1:0] tlb_c0   [TLBNUM];
    logic                        tlb_d0   [TLBNUM];
    logic                        tlb_v0   [TLBNUM];
    logic [mmu_pkg::PFN_W-1:0]   tlb_pfn1 [TLBNUM];
    logic [mmu_pkg::CATTR_W-1:0] tlb_c1   [TLBNUM];
    logic                        tlb_d1   [TLBNUM];
    logic                        tlb_v1   [TLBNUM];

    // per search port: [0] fetch, [1] data or probe
    logic [1:0][mmu_pkg::VPN2_W-1:0]  q_vpn2;
    logic [1:0][mmu_pkg::ASID_W-1:0]  q_asid;
    logic [1:0]                       q_odd;
    logic [1:0][TLBNUM-1:0]           match;
    logic [1:0][IDX_W-1:0]            hit_index;
    logic [1:0]                       found;
    logic [1:0][mmu_pkg::PFN_W-1:0]   pfn;
    logic [1:0][mmu_pkg::CATTR_W-1:0] cattr;
    logic [1:0]                       dirty;
    logic [1:0]                       valid;
    logic [TLBNUM-1:0]                live;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLBNUM; i++) begin
                tlb_vpn2[i] <= '0;
                tlb_asid[i] <= '0;
                tlb_g[i]    <= 1'b0;
                tlb_pfn0[i] <= '0;
                tlb_c0[i]   <= '0;
                tlb_d0[i]   <= 1'b0;
                tlb_v0[i]   <= 1'b0;
                tlb_pfn1[i] <= '0;
                tlb_c1[i]   <= '0;
                tlb_d1[i]   <= 1'b0;
                tlb_v1[i]   <= 1'b0;
            end
        end else if (inst_tlbwi) begin
            tlb_vpn2[w_index] <= w_vpn2;
            tlb_asid[w_index] <= w_asid;
            tlb_g[w_index]    <= w_g;
            tlb_pfn0[w_index] <= w_pfn0;
            tlb_c0[w_index]   <= w_c0;
            tlb_d0[w_index]   <= w_d0;
            tlb_v0[w_index]   <= w_v0;
            tlb_pfn1[w_index] <= w_pfn1;
            tlb_c1[w_index]   <= w_c1;
            tlb_d1[w_index]   <= w_d1;
            tlb_v1[w_index]   <= w_v1;
        end
    end

    // indexed read for tlbr
    assign r_vpn2 = tlb_vpn2[w_index];
    assign r_asid = tlb_asid[w_index];
    assign r_g    = tlb_g[w_index];
    assign r_pfn0 = tlb_pfn0[w_index];
    assign r_c0   = tlb_c0[w_index];
    assign r_d0   = tlb_d0[w_index];
    assign r_v0   = tlb_v0[w_index];
    assign r_pfn1 = tlb_pfn1[w_index];
    assign r_c1   = tlb_c1[w_index];
    assign r_d1   = tlb_d1[w_index];
    assign r_v1   = tlb_v1[w_index];

    assign q_vpn2[0] = s0_vpn2;
    assign q_asid[0] = s0_asid;
    assign q_odd[0]  = s0_odd_page;
    assign q_vpn2[1] = inst_tlbp ? w_vpn2 : s1_vpn2;   // probe borrows port 1
    assign q_asid[1] = inst_tlbp ? w_asid : s1_asid;
    assign q_odd[1]  = s1_odd_page;

    for (genvar e = 0; e < TLBNUM; e++) begin : g_live
        assign live[e] = tlb_v0[e] | tlb_v1[e];
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        for (genvar e = 0; e < TLBNUM; e++) begin : g_match
            assign match[p][e] = (q_vpn2[p] == tlb_vpn2[e]) &&
                                 ((q_asid[p] == tlb_asid[e]) || tlb_g[e]);
        end

        // one-hot to binary, each index bit ORs the entries that have it set
        for (genvar b = 0; b < IDX_W; b++) begin : g_enc
            logic [TLBNUM-1:0] sel;
            for (genvar e = 0; e < TLBNUM; e++) begin : g_sel
                assign sel[e] = match[p][e] && (((e >> b) & 1) == 1);
            end
            assign hit_index[p][b] = |sel;
        end

        assign found[p] = |match[p];
        assign pfn[p]   = !found[p] ? '0 :
                          q_odd[p] ? tlb_pfn1[hit_index[p]] : tlb_pfn0[hit_index[p]];
        assign cattr[p] = !found[p] ? '0 :
                          q_odd[p] ? tlb_c1[hit_index[p]] : tlb_c0[hit_index[p]];
        assign dirty[p] = found[p] &&
                          (q_odd[p] ? tlb_d1[hit_index[p]] : tlb_d0[hit_index[p]]);
        assign valid[p] = found[p] &&
                          (q_odd[p] ? tlb_v1[hit_index[p]] : tlb_v0[hit_index[p]]);

        // never-written entries all hold vpn2 0, so only live ones count
        assert property (@(posedge clk) disable iff (reset) $onehot0(match[p] & live))
            else $error("tlb: duplicate match on search port %0d", p);
    end

    assign s0_found = found[0];
    assign s0_pfn   = pfn[0];
    assign s0_c     = cattr[0];
    assign s0_d     = dirty[0];
    assign s0_v     = valid[0];

    assign s1_found = found[1];
    assign s1_pfn   = pfn[1];
    assign s1_c     = cattr[1];
    assign s1_d     = dirty[1];
    assign s1_v     = valid[1];

    assign probe_found = found[1];
    assign probe_index = hit_index[1];

endmodule

// File: hw/tlb_cp0_regs.sv
`timescale 1ns/100ps

module tlb_cp0_regs #(
    parameter int TLBNUM = 16
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          cp0_we,
    input  mmu_pkg::cp0_reg_e             cp0_addr,
    input  logic [31:0]                   cp0_wdata,
    input  mmu_pkg::tlb_op_e              tlb_op,
    output logic [31:0]                   cp0_rdata,
    output logic [mmu_pkg::ASID_W-1:0]    cur_asid,

    output logic                          inst_tlbwi,
    output logic                          inst_tlbp,
    output logic [$clog2(TLBNUM)-1:0]     w_index,
    output logic [mmu_pkg::VPN2_W-1:0]    w_vpn2,
    output logic [mmu_pkg::ASID_W-1:0]    w_asid,
    output logic                          w_g,
    output logic [mmu_pkg::PFN_W-1:0]     w_pfn0,
    output logic [mmu_pkg::CATTR_W-1:0]   w_c0,
    output logic                          w_d0,
    output logic                          w_v0,
    output logic [mmu_pkg::PFN_W-1:0]     w_pfn1,
    output logic [mmu_pkg::CATTR_W-1:0]   w_c1,
    output logic                          w_d1,
    output logic                          w_v1,

    input  logic                          probe_found,
    input  logic [$clog2(TLBNUM)-1:0]     probe_index,
    input  logic [mmu_pkg::VPN2_W-1:0]    r_vpn2,
    input  logic [mmu_pkg::ASID_W-1:0]    r_asid,
    input  logic                          r_g,
    input  logic [mmu_pkg::PFN_W-1:0]     r_pfn0,
    input  logic [mmu_pkg::CATTR_W-1:0]   r_c0,
    input  logic                          r_d0,
    input  logic                          r_v0,
    input  logic [mmu_pkg::PFN_W-1:0]     r_pfn1,
    input  logic [mmu_pkg::CATTR_W-1:0]   r_c1,
    input  logic                          r_d1,
    input  logic                          r_v1
);

    localparam int IDX_W = $clog2(TLBNUM);
    localparam int LO_W  = mmu_pkg::LO_PFN_LSB + mmu_pkg::PFN_W;   // pfn,c,d,v,g

    logic                       index_p;      // probe miss
    logic [IDX_W-1:0]           index_val;
    logic [mmu_pkg::VPN2_W-1:0] hi_vpn2;
    logic [mmu_pkg::ASID_W-1:0] hi_asid;
    logic [LO_W-1:0]            lo0;
    logic [LO_W-1:0]            lo1;

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p   <= 1'b0;
            index_val <= '0;
            hi_vpn2   <= '0;
            hi_asid   <= '0;
            lo0       <= '0;
            lo1       <= '0;
        end else if (cp0_we) begin
            case (cp0_addr)
                mmu_pkg::CP0_INDEX:    index_val <= cp0_wdata[IDX_W-1:0];  // P is read only
                mmu_pkg::CP0_ENTRYLO0: lo0 <= cp0_wdata[LO_W-1:0];
                mmu_pkg::CP0_ENTRYLO1: lo1 <= cp0_wdata[LO_W-1:0];
                mmu_pkg::CP0_ENTRYHI: begin
                    hi_vpn2 <= cp0_wdata[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W];
                    hi_asid <= cp0_wdata[mmu_pkg::ASID_W-1:0];
                end
                default: ;
            endcase
        end else if (tlb_op == mmu_pkg::TLB_P) begin
            index_p   <= !probe_found;
            index_val <= probe_index;
        end else if (tlb_op == mmu_pkg::TLB_R) begin
            hi_vpn2 <= r_vpn2;
            hi_asid <= r_asid;
            lo0     <= {r_pfn0, r_c0, r_d0, r_v0, r_g};
            lo1     <= {r_pfn1, r_c1, r_d1, r_v1, r_g};   // g shows in both halves
        end
    end

    always_comb begin
        cp0_rdata = '0;
        case (cp0_addr)
            mmu_pkg::CP0_INDEX: begin
                cp0_rdata[mmu_pkg::INDEX_P_BIT] = index_p;
                cp0_rdata[IDX_W-1:0]            = index_val;
            end
            mmu_pkg::CP0_ENTRYLO0: cp0_rdata[LO_W-1:0] = lo0;
            mmu_pkg::CP0_ENTRYLO1: cp0_rdata[LO_W-1:0] = lo1;
            mmu_pkg::CP0_ENTRYHI: begin
                cp0_rdata[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W] = hi_vpn2;
                cp0_rdata[mmu_pkg::ASID_W-1:0]                    = hi_asid;
            end
            default: ;
        endcase
    end

    assign cur_asid   = hi_asid;
    assign inst_tlbwi = (tlb_op == mmu_pkg::TLB_WI);
    assign inst_tlbp  = (tlb_op == mmu_pkg::TLB_P);
    assign w_index    = index_val;
    assign w_vpn2     = hi_vpn2;
    assign w_asid     = hi_asid;
    assign w_g        = lo0[0] & lo1[0];   // global only when both halves say so
    assign {w_pfn0, w_c0, w_d0, w_v0} = lo0[LO_W-1:1];
    assign {w_pfn1, w_c1, w_d1, w_v1} = lo1[LO_W-1:1];

    // the pipeline issues a register move and a TLB instruction in separate cycles
    assert property (@(posedge clk) disable iff (reset)
                     cp0_we |-> tlb_op == mmu_pkg::TLB_NONE)
        else $error("tlb_cp0_regs: cp0 write together with a TLB operation");

endmodule

// File: hw/addr_xlate.sv
`timescale 1ns/100ps

module addr_xlate (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          req,
    input  mmu_pkg::vaddr_u               vaddr,
    input  logic                          store,
    input  logic [mmu_pkg::ASID_W-1:0]    cur_asid,

    output logic [mmu_pkg::VPN2_W-1:0]    s_vpn2,
    output logic                          s_odd_page,
    output logic [mmu_pkg::ASID_W-1:0]    s_asid,
    input  logic                          s_found,
    input  logic [mmu_pkg::PFN_W-1:0]     s_pfn,
    input  logic [mmu_pkg::CATTR_W-1:0]   s_c,
    input  logic                          s_d,
    input  logic                          s_v,

    output logic                          valid,
    output logic [mmu_pkg::PA_W-1:0]      paddr,
    output mmu_pkg::xlate_exc_e           exc,
    output logic                          uncached
);

    logic                     unmapped;
    logic                     kseg1;
    logic [mmu_pkg::PA_W-1:0] next_paddr;
    mmu_pkg::xlate_exc_e      next_exc;
    logic                     next_uncached;

    assign s_vpn2     = vaddr.mapped.vpn2;
    assign s_odd_page = vaddr.mapped.odd;
    assign s_asid     = cur_asid;

    assign unmapped = (vaddr.raw[31:30] == 2'b10);    // kseg0 or kseg1
    assign kseg1    = (vaddr.raw[31:29] == 3'b101);

    always_comb begin
        next_paddr    = '0;
        next_exc      = mmu_pkg::EXC_NONE;
        next_uncached = 1'b0;
        if (unmapped) begin
            next_paddr    = {3'b000, vaddr.raw[28:0]};
            next_uncached = kseg1;
        end else if (!s_found) begin
            next_exc = mmu_pkg::EXC_REFILL;
        end else if (!s_v) begin
            next_exc = mmu_pkg::EXC_INVALID;
        end else if (store && !s_d) begin
            next_exc = mmu_pkg::EXC_MODIFIED;
        end else begin
            next_paddr    = {s_pfn, vaddr.mapped.offset};
            next_uncached = (s_c == mmu_pkg::CATTR_UNCACHED);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            paddr    <= next_paddr;
            exc      <= next_exc;
            uncached <= next_uncached;
        end
    end

endmodule

// File: hw/mmu_top.sv
`timescale 1ns/100ps

module mmu_top #(
    parameter int TLBNUM = 16
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       cp0_we,
    input  mmu_pkg::cp0_reg_e          cp0_addr,
    input  logic [31:0]                cp0_wdata,
    output logic [31:0]                cp0_rdata,
    input  mmu_pkg::tlb_op_e           tlb_op,

    input  logic                       if_req,
    input  logic [mmu_pkg::VA_W-1:0]   if_vaddr,
    output logic                       if_valid,
    output logic [mmu_pkg::PA_W-1:0]   if_paddr,
    output mmu_pkg::xlate_exc_e        if_exc,
    output logic                       if_uncached,

    input  logic                       dm_req,
    input  logic [mmu_pkg::VA_W-1:0]   dm_vaddr,
    input  logic                       dm_store,
    output logic                       dm_valid,
    output logic [mmu_pkg::PA_W-1:0]   dm_paddr,
    output mmu_pkg::xlate_exc_e        dm_exc,
    output logic                       dm_uncached
);

    localparam int IDX_W = $clog2(TLBNUM);

    logic [mmu_pkg::ASID_W-1:0]  cur_asid;
    logic                        inst_tlbwi;
    logic                        inst_tlbp;
    logic [IDX_W-1:0]            w_index;
    logic [mmu_pkg::VPN2_W-1:0]  w_vpn2;
    logic [mmu_pkg::ASID_W-1:0]  w_asid;
    logic                        w_g;
    logic [mmu_pkg::PFN_W-1:0]   w_pfn0;
    logic [mmu_pkg::PFN_W-1:0]   w_pfn1;
    logic [mmu_pkg::CATTR_W-1:0] w_c0;
    logic [mmu_pkg::CATTR_W-1:0] w_c1;
    logic                        w_d0;
    logic                        w_d1;
    logic                        w_v0;
    logic                        w_v1;
    logic                        probe_found;
    logic [IDX_W-1:0]            probe_index;
    logic [mmu_pkg::VPN2_W-1:0]  r_vpn2;
    logic [mmu_pkg::ASID_W-1:0]  r_asid;
    logic                        r_g;
    logic [mmu_pkg::PFN_W-1:0]   r_pfn0;
    logic [mmu_pkg::PFN_W-1:0]   r_pfn1;
    logic [mmu_pkg::CATTR_W-1:0] r_c0;
    logic [mmu_pkg::CATTR_W-1:0] r_c1;
    logic                        r_d0;
    logic                        r_d1;
    logic                        r_v0;
    logic                        r_v1;

    logic [mmu_pkg::VPN2_W-1:0]  s0_vpn2;
    logic [mmu_pkg::VPN2_W-1:0]  s1_vpn2;
    logic [mmu_pkg::ASID_W-1:0]  s0_asid;
    logic [mmu_pkg::ASID_W-1:0]  s1_asid;
    logic [mmu_pkg::PFN_W-1:0]   s0_pfn;
    logic [mmu_pkg::PFN_W-1:0]   s1_pfn;
    logic [mmu_pkg::CATTR_W-1:0] s0_c;
    logic [mmu_pkg::CATTR_W-1:0] s1_c;
    logic                        s0_odd_page;
    logic                        s1_odd_page;
    logic                        s0_found;
    logic                        s1_found;
    logic                        s0_d;
    logic                        s1_d;
    logic                        s0_v;
    logic                        s1_v;

    tlb_cp0_regs #(.TLBNUM(TLBNUM)) u_regs (
        .clk, .reset,
        .cp0_we, .cp0_addr, .cp0_wdata, .tlb_op, .cp0_rdata, .cur_asid,
        .inst_tlbwi, .inst_tlbp, .w_index, .w_vpn2, .w_asid, .w_g,
        .w_pfn0, .w_c0, .w_d0, .w_v0, .w_pfn1, .w_c1, .w_d1, .w_v1,
        .probe_found, .probe_index, .r_vpn2, .r_asid, .r_g,
        .r_pfn0, .r_c0, .r_d0, .r_v0, .r_pfn1, .r_c1, .r_d1, .r_v1
    );

    tlb #(.TLBNUM(TLBNUM)) u_tlb (
        .clk, .reset,
        .s0_vpn2, .s0_odd_page, .s0_asid, .s0_found, .s0_pfn, .s0_c, .s0_d, .s0_v,
        .s1_vpn2, .s1_odd_page, .s1_asid, .s1_found, .s1_pfn, .s1_c, .s1_d, .s1_v,
        .inst_tlbwi, .inst_tlbp, .w_index, .w_vpn2, .w_asid, .w_g,
        .w_pfn0, .w_c0, .w_d0, .w_v0, .w_pfn1, .w_c1, .w_d1, .w_v1,
        .probe_found, .probe_index, .r_vpn2, .r_asid, .r_g,
        .r_pfn0, .r_c0, .r_d0, .r_v0, .r_pfn1, .r_c1, .r_d1, .r_v1
    );

    addr_xlate u_if_xlate (
        .clk, .reset,
        .req(if_req), .vaddr(if_vaddr), .store(1'b0), .cur_asid,
        .s_vpn2(s0_vpn2), .s_odd_page(s0_odd_page), .s_asid(s0_asid),
        .s_found(s0_found), .s_pfn(s0_pfn), .s_c(s0_c), .s_d(s0_d), .s_v(s0_v),
        .valid(if_valid), .paddr(if_paddr), .exc(if_exc), .uncached(if_uncached)
    );

    addr_xlate u_dm_xlate (
        .clk, .reset,
        .req(dm_req), .vaddr(dm_vaddr), .store(dm_store), .cur_asid,
        .s_vpn2(s1_vpn2), .s_odd_page(s1_odd_page), .s_asid(s1_asid),
        .s_found(s1_found), .s_pfn(s1_pfn), .s_c(s1_c), .s_d(s1_d), .s_v(s1_v),
        .valid(dm_valid), .paddr(dm_paddr), .exc(dm_exc), .uncached(dm_uncached)
    );

    // search port 1 belongs to tlbp for that cycle
    assert property (@(posedge clk) disable iff (reset)
                     tlb_op == mmu_pkg::TLB_P |-> !dm_req)
        else $error("mmu_top: data request during tlbp");

endmodule

// File: tb/tb_mmu.sv
`timescale 1ns/100ps

module tb_mmu;

    typedef struct packed {
        logic [31:0] va;
        logic        store;
        logic [1:0]  exc;
        logic [31:0] pa;
        logic        unc;
    } lookup_t;

    logic                     clk;
    logic                     reset;
    logic                     cp0_we;
    mmu_pkg::cp0_reg_e        cp0_addr;
    logic [31:0]              cp0_wdata;
    logic [31:0]              cp0_rdata;
    mmu_pkg::tlb_op_e         tlb_op;
    logic                     if_req;
    logic [mmu_pkg::VA_W-1:0] if_vaddr;
    logic                     if_valid;
    logic [mmu_pkg::PA_W-1:0] if_paddr;
    mmu_pkg::xlate_exc_e      if_exc;
    logic                     if_uncached;
    logic                     dm_req;
    logic [mmu_pkg::VA_W-1:0] dm_vaddr;
    logic                     dm_store;
    logic                     dm_valid;
    logic [mmu_pkg::PA_W-1:0] dm_paddr;
    mmu_pkg::xlate_exc_e      dm_exc;
    logic                     dm_uncached;

    lookup_t     if_q[$];   // k-th fetch pairs with k-th data
    lookup_t     dm_q[$];
    logic [31:0] rng_state = 32'd8998;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          tests_bad;
    string       test_name;

    mmu_top #(.TLBNUM(16)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic string word_text(logic [8*24-1:0] w);
        string s;
        s = "";
        for (int i = 23; i >= 0; i--) begin
            if (w[8*i +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", w[8*i +: 8])};
            end
        end
        return s;
    endfunction

    function automatic mmu_pkg::tlb_op_e op_from_text(string s);
        case (s)
            "P":     op_from_text = mmu_pkg::TLB_P;
            "R":     op_from_text = mmu_pkg::TLB_R;
            "WI":    op_from_text = mmu_pkg::TLB_WI;
            default: op_from_text = mmu_pkg::TLB_NONE;
        endcase
    endfunction

    function automatic lookup_t make_lookup(logic [31:0] va, logic [31:0] st, logic [31:0] ex,
                                            logic [31:0] pa, logic [31:0] un);
        lookup_t     e;
        logic [31:0] r;
        r = next_random();
        e.va = va;
        e.store = st[0];
        e.exc = ex[1:0];
        e.pa = pa;
        e.unc = un[0];
        if (va[31:30] != 2'b10) begin   // offset passes straight through on mapped pages
            e.va[11:0] = r[11:0];
            if (ex == 0) begin
                e.pa[11:0] = r[11:0];
            end
        end
        return e;
    endfunction

    task automatic check_exc(input string name, input mmu_pkg::xlate_exc_e got,
                             input mmu_pkg::xlate_exc_e exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %s, expected %s", $time, name, got.name(), exp.name());
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_paddr(input string name, input logic [mmu_pkg::PA_W-1:0] got,
                               input logic [mmu_pkg::PA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_cp0(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors != 0) begin
                tests_bad++;
            end
            $display("test %-16s %s (%0d errors)", test_name,
                     test_errors == 0 ? "ok" : "bad", test_errors);
        end
        test_errors = 0;
    endtask

    task automatic write_cp0(input logic [31:0] regno, input logic [31:0] value);
        @(posedge clk);
        cp0_we    <= 1'b1;
        cp0_addr  <= mmu_pkg::cp0_reg_e'(regno[4:0]);
        cp0_wdata <= value;
        @(posedge clk);
        cp0_we    <= 1'b0;
    endtask

    task automatic read_cp0(input logic [31:0] regno, input logic [31:0] exp);
        @(posedge clk);
        cp0_addr <= mmu_pkg::cp0_reg_e'(regno[4:0]);
        @(negedge clk);   // rdata is combinational
        check_cp0($sformatf("cp0_rdata[%0d]", regno), cp0_rdata, exp);
    endtask

    task automatic run_tlb_op(input mmu_pkg::tlb_op_e op);
        @(posedge clk);
        tlb_op <= op;
        @(posedge clk);
        tlb_op <= mmu_pkg::TLB_NONE;
    endtask

    task automatic wait_valid(input bit want_if, input bit want_dm, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 20 && !ok; n++) begin
            @(negedge clk);
            ok = (!want_if || if_valid) && (!want_dm || dm_valid);
        end
    endtask

    // results checked one cycle behind their requests
    task automatic run_lookups();
        int n;
        bit ok;
        n = (if_q.size() > dm_q.size()) ? if_q.size() : dm_q.size();
        for (int k = 0; k <= n && n > 0; k++) begin
            @(posedge clk);
            if_req <= (k < if_q.size());
            dm_req <= (k < dm_q.size());
            if (k < if_q.size()) begin
                if_vaddr <= if_q[k].va;
            end
            if (k < dm_q.size()) begin
                dm_vaddr <= dm_q[k].va;
                dm_store <= dm_q[k].store;
            end
            if (k > 0) begin
                wait_valid(k - 1 < if_q.size(), k - 1 < dm_q.size(), ok);
                if (!ok) begin
                    $display("timeout: lookup %0d got no valid within 20 cycles", k - 1);
                    errors++;
                    test_errors++;
                    if_req <= 1'b0;
                    dm_req <= 1'b0;
                    break;
                end
                check_bit("if_valid", if_valid, k - 1 < if_q.size());
                check_bit("dm_valid", dm_valid, k - 1 < dm_q.size());
                if (k - 1 < if_q.size()) begin
                    check_exc("if_exc", if_exc, mmu_pkg::xlate_exc_e'(if_q[k-1].exc));
                    check_paddr("if_paddr", if_paddr, if_q[k-1].pa);
                    check_bit("if_uncached", if_uncached, if_q[k-1].unc);
                end
                if (k - 1 < dm_q.size()) begin
                    check_exc("dm_exc", dm_exc, mmu_pkg::xlate_exc_e'(dm_q[k-1].exc));
                    check_paddr("dm_paddr", dm_paddr, dm_q[k-1].pa);
                    check_bit("dm_uncached", dm_uncached, dm_q[k-1].unc);
                end
            end
        end
        if_q.delete();
        dm_q.delete();
    endtask

    initial begin
        int               fd;
        int               code;
        logic [8*24-1:0]  tok;
        logic [8*24-1:0]  arg;
        logic [8*128-1:0] line_buf;
        logic [31:0]      f[5];
        string            cmd;
        bit               done;

        reset = 1'b1;
        cp0_we = 1'b0;
        cp0_addr = mmu_pkg::CP0_INDEX;
        cp0_wdata = '0;
        tlb_op = mmu_pkg::TLB_NONE;
        if_req = 1'b0;
        if_vaddr = '0;
        dm_req = 1'b0;
        dm_vaddr = '0;
        dm_store = 1'b0;
        errors = 0;
        checks = 0;
        test_errors = 0;
        tests_run = 0;
        tests_bad = 0;
        test_name = "";
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/mmu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/mmu_stimulus.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                cmd = word_text(tok);
                if (code != 1) begin
                    run_lookups();
                    close_test();
                    done = 1'b1;
                end else if (cmd == "I" || cmd == "D") begin
                    code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    if (cmd == "I") begin
                        if_q.push_back(make_lookup(f[0], f[1], f[2], f[3], f[4]));
                    end else begin
                        dm_q.push_back(make_lookup(f[0], f[1], f[2], f[3], f[4]));
                    end
                end else begin
                    run_lookups();   // any other command ends a lookup batch
                    if (cmd[0] == "#") begin
                        code = $fgets(line_buf, fd);
                    end else if (cmd == "N") begin
                        close_test();
                        code = $fscanf(fd, "%s", arg);
                        test_name = word_text(arg);
                    end else if (cmd == "W") begin
                        code = $fscanf(fd, "%h %h", f[0], f[1]);
                        write_cp0(f[0], f[1]);
                    end else if (cmd == "R") begin
                        code = $fscanf(fd, "%h %h", f[0], f[1]);
                        read_cp0(f[0], f[1]);
                    end else if (cmd == "T") begin
                        code = $fscanf(fd, "%s", arg);
                        run_tlb_op(op_from_text(word_text(arg)));
                    end else begin
                        $display("unknown command '%s' in stimulus file", cmd);
                        errors++;
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/mmu_pkg.sv
hw/tlb.sv
hw/tlb_cp0_regs.sv
hw/addr_xlate.sv
hw/mmu_top.sv
tb/tb_mmu.sv

// File: run.sh
#!/bin/sh
# build the MMU testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mmu -f flist.f -o tb_mmu_sim \
    && ./obj_dir/tb_mmu_sim 2>&1 | tee sim.log \
    || echo "build or simulation did not complete" | tee -a sim.log
grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/mmu_stimulus.txt
# N name | W reg value | R reg expected | T op (P R WI), numbers in hex
# I/D vaddr store exc paddr uncached, exc 0 none 1 refill 2 invalid 3 modified
N reset_state
I 00400000 0 1 00000000 0
D 00401000 0 1 00000000 0
R 0 00000000
R 2 00000000
R 3 00000000
R a 00000000
N write_translate
W 0 00000005
W a 00400012
W 2 0048D15E
W 3 002AF356
T WI
I 00400000 0 0 12345000 0
D 00401000 0 0 0ABCD000 1
N exceptions
W 0 00000006
W a 00800012
W 2 0000445A
W 3 0000889C
T WI
D 00800000 1 3 00000000 0
D 00800000 0 0 00111000 0
D 00801000 0 2 00000000 0
I 00801000 0 2 00000000 0
W a 00800034
D 00800000 0 1 00000000 0
W 0 00000007
W a 00C00012
W 2 0000CCDF
W 3 0001111F
T WI
W a 00000034
D 00C01000 0 0 00444000 0
I 00C00000 0 0 00333000 0
N probe_read
W a 00800012
T P
R 0 00000006
W a 00800034
T P
R 0 80000000
W a 00C00099
T P
R 0 00000007
W 0 00000005
T R
R a 00400012
R 2 0048D15E
R 3 002AF356
W 0 00000007
T R
R a 00C00012
R 2 0000CCDF
R 3 0001111F
N unmapped
W 0 00000008
W a 80000012
W 2 0001555E
W 3 00000000
T WI
I 80000010 0 0 00000010 0
D A0001234 0 0 00001234 1
I BFC00380 0 0 1FC00380 1
D 9FFFFFF0 1 0 1FFFFFF0 0
N concurrent
I 00400000 0 0 12345000 0
I 00401000 0 0 0ABCD000 1
I 00C00000 0 0 00333000 0
I 00600000 0 1 00000000 0
I 80000020 0 0 00000020 0
D 00401000 0 0 0ABCD000 1
D 00800000 0 0 00111000 0
D 00401000 1 0 0ABCD000 1
D A0000100 0 0 00000100 1
D 00800000 1 3 00000000 0
